// File: src/mem_config.svh
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// data and address width.
`define MEM_XLEN 32
// ram size in words.
`define MEM_DEPTH_WORDS 256
// low address bits that pick the byte lane.
`define MEM_ADDR_LSB 2
// request queue entries.
`define MEM_QUEUE_DEPTH 4
// tag carried from issue to response.
`define MEM_TAG_W 4

`define MEM_BYTES (`MEM_XLEN / 8)
`define MEM_RAM_AW $clog2(`MEM_DEPTH_WORDS)

`endif

// File: src/mem_req_pkg.sv
`default_nettype none

`include "mem_config.svh"

package mem_req_pkg;

    // load and store opcodes.
    typedef enum logic [2:0] {LB, LH, LW, LBU, LHU, SB, SH, SW} mem_op_e;

    typedef struct packed {
        mem_op_e                 op;
        logic [`MEM_XLEN-1:0]    addr;
        logic [`MEM_XLEN-1:0]    wdata;
        logic [`MEM_TAG_W-1:0]   tag;
    } mem_issue_t;

    typedef struct packed {
        mem_op_e                              op;
        logic [`MEM_XLEN-`MEM_ADDR_LSB-1:0]   word_addr;
        logic [`MEM_ADDR_LSB-1:0]             lane;
        logic [`MEM_BYTES-1:0]                mask;   // before lane shift.
        logic [`MEM_XLEN-1:0]                 wdata;  // before lane shift.
        logic [`MEM_TAG_W-1:0]                tag;
        logic                                 misaligned;
    } mem_req_t;

endpackage

`default_nettype wire

// File: src/mem_resp_pkg.sv
`default_nettype none

`include "mem_config.svh"

package mem_resp_pkg;

    // controller states.
    typedef enum logic {IDLE, READ} ctrl_state_e;

    typedef struct packed {
        logic [`MEM_TAG_W-1:0]   tag;
        logic [`MEM_XLEN-1:0]    rdata;  // zero for stores and errors.
        logic                    err;
    } mem_resp_t;

endpackage

`default_nettype wire

// File: src/lsu_issue.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_config.svh"

module lsu_issue (
    input  wire                         clk,
    input  wire                         rst,
    input  wire mem_req_pkg::mem_issue_t issue,
    input  wire                         issue_valid,
    output mem_req_pkg::mem_req_t       req,
    output logic                        req_valid
);
    import mem_req_pkg::*;

    logic                       is_half;
    logic                       is_word;
    logic [`MEM_ADDR_LSB-1:0]   lane;
    logic [`MEM_BYTES-1:0]      mask;
    logic                       misaligned;

    assign lane = issue.addr[`MEM_ADDR_LSB-1:0];

    always_comb begin
        is_half = 1'b0;
        is_word = 1'b0;
        case (issue.op)
            LH, LHU, SH: is_half = 1'b1;
            LW, SW:      is_word = 1'b1;
            default:     ;  // byte access.
        endcase
    end

    assign mask = is_word ? '1 : (is_half ? `MEM_BYTES'(2'b11) : `MEM_BYTES'(1'b1));

    // no access may cross a word boundary.
    assign misaligned = (is_half && lane[0]) || (is_word && (lane != '0));

    always_ff @(posedge clk) begin
        if (rst) begin
            req_valid <= 1'b0;
        end else begin
            req_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            req.op         <= issue.op;
            req.word_addr  <= issue.addr[`MEM_XLEN-1:`MEM_ADDR_LSB];
            req.lane       <= lane;
            req.mask       <= mask;
            req.wdata      <= issue.wdata;
            req.tag        <= issue.tag;
            req.misaligned <= misaligned;
        end
    end

endmodule

`default_nettype wire

// File: src/req_queue.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_config.svh"

module req_queue (
    input  wire                         clk,
    input  wire                         rst,
    input  wire mem_req_pkg::mem_req_t  req,
    input  wire                         req_valid,
    output mem_req_pkg::mem_req_t       head,
    output logic                        head_valid,
    input  wire                         pop,
    output logic                        overflow
);
    import mem_req_pkg::*;

    localparam int PTR_W = $clog2(`MEM_QUEUE_DEPTH);
    localparam int CNT_W = $clog2(`MEM_QUEUE_DEPTH + 1);

    mem_req_t           entries [`MEM_QUEUE_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               full;
    logic               do_push;
    logic               do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(`MEM_QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full       = (count == CNT_W'(`MEM_QUEUE_DEPTH));
    assign do_pop     = pop && head_valid;
    assign do_push    = req_valid && (!full || do_pop);  // a pop frees the slot.
    assign head       = entries[rd_ptr];
    assign head_valid = (count != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            if (req_valid && !do_push) begin
                overflow <= 1'b1;  // sticky until reset.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= req;
        end
    end

endmodule

`default_nettype wire

// File: src/mem_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_config.svh"

module mem_ctrl (
    input  wire                         clk,
    input  wire                         rst,
    input  wire mem_req_pkg::mem_req_t  head,
    input  wire                         head_valid,
    output logic                        pop,
    output logic                        ram_en,
    output logic                        ram_we,
    output logic [`MEM_RAM_AW-1:0]      ram_addr,
    output logic [`MEM_BYTES-1:0]       ram_be,
    output logic [`MEM_XLEN-1:0]        ram_wdata,
    input  wire  [`MEM_XLEN-1:0]        ram_rdata,
    output mem_resp_pkg::mem_resp_t     resp,
    output logic                        resp_valid
);
    import mem_req_pkg::*;
    import mem_resp_pkg::*;

    ctrl_state_e                state;
    mem_op_e                    ld_op;
    logic [`MEM_ADDR_LSB-1:0]   ld_lane;
    logic [`MEM_TAG_W-1:0]      ld_tag;
    logic                       is_store;
    logic [`MEM_XLEN-1:0]       rd_shift;
    logic [`MEM_XLEN-1:0]       rd_ext;

    assign is_store = head.op inside {SB, SH, SW};

    // one gap cycle while a response is out.
    assign pop = (state == IDLE) && head_valid && !resp_valid;

    assign ram_en    = pop && !head.misaligned;
    assign ram_we    = ram_en && is_store;
    assign ram_addr  = head.word_addr[`MEM_RAM_AW-1:0];
    assign ram_be    = head.mask << head.lane;
    assign ram_wdata = head.wdata << {head.lane, 3'b000};

    // move the addressed bytes down to bit 0.
    assign rd_shift = ram_rdata >> {ld_lane, 3'b000};

    always_comb begin
        case (ld_op)
            LB:      rd_ext = {{(`MEM_XLEN - 8){rd_shift[7]}}, rd_shift[7:0]};
            LH:      rd_ext = {{(`MEM_XLEN - 16){rd_shift[15]}}, rd_shift[15:0]};
            LBU:     rd_ext = {{(`MEM_XLEN - 8){1'b0}}, rd_shift[7:0]};
            LHU:     rd_ext = {{(`MEM_XLEN - 16){1'b0}}, rd_shift[15:0]};
            default: rd_ext = rd_shift;  // lw.
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (pop) begin
                        if (is_store || head.misaligned) begin
                            resp_valid <= 1'b1;
                        end else begin
                            state <= READ;
                        end
                    end
                end
                READ: begin
                    resp_valid <= 1'b1;  // ram data is valid now.
                    state      <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            ld_op      <= head.op;
            ld_lane    <= head.lane;
            ld_tag     <= head.tag;
            resp.tag   <= head.tag;
            resp.rdata <= '0;
            resp.err   <= head.misaligned;
        end else if (state == READ) begin
            resp.tag   <= ld_tag;
            resp.rdata <= rd_ext;
            resp.err   <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: src/data_sram.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_config.svh"

module data_sram (
    input  wire                     clk,
    input  wire                     en,
    input  wire                     we,
    input  wire [`MEM_RAM_AW-1:0]   addr,
    input  wire [`MEM_BYTES-1:0]    be,
    input  wire [`MEM_XLEN-1:0]     wdata,
    output logic [`MEM_XLEN-1:0]    rdata
);

    logic [`MEM_XLEN-1:0] mem [`MEM_DEPTH_WORDS];

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                for (int i = 0; i < `MEM_BYTES; i++) begin
                    if (be[i]) begin
                        mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
                    end
                end
            end
            rdata <= mem[addr];  // old contents on a write.
        end
    end

endmodule

`default_nettype wire

// File: src/mem_subsys_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_config.svh"

module mem_subsys_top (
    input  wire                          clk,
    input  wire                          rst,
    input  wire mem_req_pkg::mem_issue_t issue,
    input  wire                          issue_valid,
    output mem_resp_pkg::mem_resp_t      resp,
    output logic                         resp_valid,
    output logic                         overflow
);
    import mem_req_pkg::*;

    mem_req_t                   req;
    logic                       req_valid;
    mem_req_t                   head;
    logic                       head_valid;
    logic                       pop;
    logic                       ram_en;
    logic                       ram_we;
    logic [`MEM_RAM_AW-1:0]     ram_addr;
    logic [`MEM_BYTES-1:0]      ram_be;
    logic [`MEM_XLEN-1:0]       ram_wdata;
    logic [`MEM_XLEN-1:0]       ram_rdata;

    lsu_issue u_lsu_issue (
        .clk         (clk),
        .rst         (rst),
        .issue       (issue),
        .issue_valid (issue_valid),
        .req         (req),
        .req_valid   (req_valid)
    );

    req_queue u_req_queue (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .req_valid  (req_valid),
        .head       (head),
        .head_valid (head_valid),
        .pop        (pop),
        .overflow   (overflow)
    );

    mem_ctrl u_mem_ctrl (
        .clk        (clk),
        .rst        (rst),
        .head       (head),
        .head_valid (head_valid),
        .pop        (pop),
        .ram_en     (ram_en),
        .ram_we     (ram_we),
        .ram_addr   (ram_addr),
        .ram_be     (ram_be),
        .ram_wdata  (ram_wdata),
        .ram_rdata  (ram_rdata),
        .resp       (resp),
        .resp_valid (resp_valid)
    );

    data_sram u_data_sram (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .be    (ram_be),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

`default_nettype wire

// File: sim/tb_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD = 20;
    localparam int RST_CYCLES  = 5;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;  // released just after an edge.
    end

endmodule

`default_nettype wire

// File: sim/mem_ctrl_checker.sv
`timescale 1ns/1ns
`default_nettype none

module mem_ctrl_checker (
    input wire                          clk,
    input wire                          rst,
    input wire mem_req_pkg::mem_req_t   head,
    input wire                          head_valid,
    input wire                          pop,
    input wire                          ram_we,
    input wire mem_resp_pkg::mem_resp_t resp,
    input wire                          resp_valid
);

    // a misaligned pop writes nothing and answers with err.
    no_misaligned_write: assert property (
        @(posedge clk) disable iff (rst)
        (pop && head.misaligned) |-> !ram_we ##1 (resp_valid && resp.err)
    ) else $error("misaligned request wrote the ram or got no err response");

    // stores answer after one cycle, loads after two.
    resp_after_pop: assert property (
        @(posedge clk) disable iff (rst)
        resp_valid |-> ($past(pop) || $past(pop, 2))
    ) else $error("response without a pop one or two cycles before");

    // one pop per queued item.
    pop_needs_head: assert property (
        @(posedge clk) disable iff (rst)
        pop |-> head_valid ##1 !pop
    ) else $error("pop while the queue is empty or on two cycles in a row");

endmodule

`default_nettype wire

// File: sim/mem_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_config.svh"

module mem_tb;
    import mem_req_pkg::*;
    import mem_resp_pkg::*;

    localparam int MAX_WAIT_CYCLES = 200;
    localparam int BYTE_AW = `MEM_RAM_AW + `MEM_ADDR_LSB;
    localparam int BURST_LEN = 12;

    logic                    clk;
    logic                    rst_init;
    logic                    rst_pulse;
    logic                    rst;
    mem_issue_t              issue;
    logic                    issue_valid;
    mem_resp_t               resp;
    logic                    resp_valid;
    logic                    overflow;

    logic [7:0]              ref_mem [`MEM_DEPTH_WORDS * `MEM_BYTES];
    mem_resp_t               exp_q [$];
    logic [`MEM_TAG_W-1:0]   next_tag;
    logic                    burst_mode;
    int                      resp_count;
    logic [`MEM_XLEN-1:0]    word_addrs [BURST_LEN];

    assign rst = rst_init || rst_pulse;

    tb_clk_gen u_tb_clk_gen (
        .clk (clk),
        .rst (rst_init)
    );

    mem_subsys_top u_mem_subsys_top (
        .clk         (clk),
        .rst         (rst),
        .issue       (issue),
        .issue_valid (issue_valid),
        .resp        (resp),
        .resp_valid  (resp_valid),
        .overflow    (overflow)
    );

    bind mem_ctrl mem_ctrl_checker u_mem_ctrl_checker (
        .clk        (clk),
        .rst        (rst),
        .head       (head),
        .head_valid (head_valid),
        .pop        (pop),
        .ram_we     (ram_we),
        .resp       (resp),
        .resp_valid (resp_valid)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_eq(input string what, input logic [31:0] actual,
                            input logic [31:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("Fail at %0t ns: %s is %h, expected %h",
                               $time, what, actual, expected));
        end
    endtask

    function automatic logic is_misaligned(input mem_op_e op, input logic [31:0] addr);
        case (op)
            LH, LHU, SH: return addr[0];
            LW, SW:      return addr[1:0] != 2'b00;
            default:     return 1'b0;
        endcase
    endfunction

    // little endian, bytes read straight from the model.
    function automatic logic [31:0] load_value(input mem_op_e op, input logic [31:0] addr);
        int a;
        a = int'(addr[BYTE_AW-1:0]);
        case (op)
            LB:      return {{24{ref_mem[a][7]}}, ref_mem[a]};
            LBU:     return {24'h0, ref_mem[a]};
            LH:      return {{16{ref_mem[a+1][7]}}, ref_mem[a+1], ref_mem[a]};
            LHU:     return {16'h0, ref_mem[a+1], ref_mem[a]};
            default: return {ref_mem[a+3], ref_mem[a+2], ref_mem[a+1], ref_mem[a]};
        endcase
    endfunction

    task automatic store_ref(input mem_op_e op, input logic [31:0] addr,
                             input logic [31:0] data);
        int a;
        int n;
        a = int'(addr[BYTE_AW-1:0]);
        n = (op == SB) ? 1 : ((op == SH) ? 2 : 4);
        for (int i = 0; i < n; i++) begin
            ref_mem[a+i] = data[i*8 +: 8];
        end
    endtask

    // one strobe, expected response queued first.
    task automatic send_op(input mem_op_e op, input logic [31:0] addr, input logic [31:0] data);
        mem_resp_t want;
        logic      bad;
        bad        = is_misaligned(op, addr);
        want.tag   = next_tag;
        want.err   = bad;
        want.rdata = '0;
        if (!bad && (op inside {SB, SH, SW})) begin
            store_ref(op, addr, data);
        end else if (!bad) begin
            want.rdata = load_value(op, addr);
        end
        exp_q.push_back(want);
        issue.op    = op;
        issue.addr  = addr;
        issue.wdata = data;
        issue.tag   = next_tag;
        issue_valid = 1'b1;
        @(posedge clk);
        #2;
        issue_valid = 1'b0;
        next_tag    = next_tag + 1'b1;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #2;
            cycles++;
            if (cycles > MAX_WAIT_CYCLES) begin
                fail_run("timeout while waiting for a response");
            end
        end
    endtask

    task automatic do_op(input mem_op_e op, input logic [31:0] addr, input logic [31:0] data);
        send_op(op, addr, data);
        wait_drain();
    endtask

    // sampled mid-cycle, away from the edge.
    always @(negedge clk) begin
        if (!rst && resp_valid) begin
            resp_count++;
            if (burst_mode) begin
                while (exp_q.size() != 0 && exp_q[0].tag != resp.tag) begin
                    exp_q.delete(0);  // dropped at the full queue.
                end
            end
            if (exp_q.size() == 0) begin
                fail_run("a response arrived that matches no pending operation");
            end else begin
                check_eq("resp tag", 32'(resp.tag), 32'(exp_q[0].tag));
                check_eq("resp rdata", resp.rdata, exp_q[0].rdata);
                check_eq("resp err", 32'(resp.err), 32'(exp_q[0].err));
                exp_q.delete(0);
            end
        end
    end

    task automatic wait_reset();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > MAX_WAIT_CYCLES) begin
                fail_run("timeout while waiting for reset to end");
            end
        end while (rst !== 1'b0);
        @(posedge clk);
        #2;
    endtask

    task automatic test_word_round_trip();
        for (int i = 0; i < BURST_LEN; i++) begin
            word_addrs[i] = $urandom & 32'h0000_03fc;
            do_op(SW, word_addrs[i], $urandom);
        end
        for (int i = 0; i < BURST_LEN; i++) begin
            do_op(LW, word_addrs[i], '0);
        end
    endtask

    task automatic test_lane_placement();
        logic [31:0] addr;
        addr = 32'h0000_0100;
        do_op(SW, addr, 32'hdead_beef);
        for (int l = 0; l < `MEM_BYTES; l++) begin
            do_op(SB, addr + l, $urandom);
            do_op(LW, addr, '0);
        end
        do_op(SH, addr, $urandom);
        do_op(LW, addr, '0);
        do_op(SH, addr + 2, $urandom);
        do_op(LW, addr, '0);
    endtask

    task automatic test_extension();
        logic [31:0] addr;
        addr = 32'h0000_0200;
        do_op(SW, addr, 32'h0);
        do_op(SB, addr, 32'h0000_0085);
        do_op(SB, addr + 1, 32'h0000_007a);
        do_op(SH, addr + 2, 32'h0000_9abc);
        for (int l = 0; l < `MEM_BYTES; l++) begin
            do_op(LB, addr + l, '0);
            do_op(LBU, addr + l, '0);
        end
        do_op(LH, addr, '0);
        do_op(LHU, addr, '0);
        do_op(LH, addr + 2, '0);
        do_op(LHU, addr + 2, '0);
    endtask

    task automatic test_misaligned();
        logic [31:0] addr;
        addr = 32'h0000_0300;
        do_op(SW, addr, 32'h1357_9bdf);
        do_op(SH, addr + 1, $urandom);
        do_op(SH, addr + 3, $urandom);
        do_op(LH, addr + 1, '0);
        do_op(LH, addr + 3, '0);
        for (int l = 1; l < `MEM_BYTES; l++) begin
            do_op(SW, addr + l, $urandom);
            do_op(LW, addr + l, '0);
        end
        do_op(LW, addr, '0);
    endtask

    task automatic test_burst();
        int start;
        int quiet;
        int cycles;
        int got;
        start      = resp_count;
        next_tag   = '0;
        burst_mode = 1'b1;
        for (int i = 0; i < BURST_LEN; i++) begin
            send_op(LW, word_addrs[i], '0);
        end
        quiet  = 0;
        cycles = 0;
        while (quiet < 8) begin
            @(posedge clk);
            #2;
            quiet = resp_valid ? 0 : quiet + 1;
            cycles++;
            if (cycles > MAX_WAIT_CYCLES) begin
                fail_run("timeout while waiting for the burst to drain");
            end
        end
        got = resp_count - start;
        check_eq("overflow after burst", 32'(overflow), 32'd1);
        if (got < `MEM_QUEUE_DEPTH || got >= BURST_LEN) begin
            fail_run($sformatf("burst gave %0d responses, outside the expected range", got));
        end
        exp_q.delete();
        burst_mode = 1'b0;
    endtask

    task automatic test_reset();
        rst_pulse = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        rst_pulse = 1'b0;
        check_eq("overflow after reset", 32'(overflow), 32'd0);
        check_eq("resp_valid after reset", 32'(resp_valid), 32'd0);
        do_op(SW, 32'h0000_03f0, $urandom);
        do_op(LW, 32'h0000_03f0, '0);
    endtask

    initial begin
        int seed;
        seed        = $urandom(32'hf6c);
        issue       = '0;
        issue_valid = 1'b0;
        rst_pulse   = 1'b0;
        next_tag    = '0;
        burst_mode  = 1'b0;
        wait_reset();
        test_word_round_trip();
        test_lane_placement();
        test_extension();
        test_misaligned();
        test_burst();
        test_reset();
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+src
src/mem_req_pkg.sv
src/mem_resp_pkg.sv
src/lsu_issue.sv
src/req_queue.sv
src/mem_ctrl.sv
src/data_sram.sv
src/mem_subsys_top.sv
sim/tb_clk_gen.sv
sim/mem_ctrl_checker.sv
sim/mem_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module mem_tb -Mdir obj_dir -f filelist.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/Vmem_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
